// ==== imuSampler.f ====
hw/imuPkg.sv
hw/i2cPkg.sv
hw/burstIf.sv
hw/i2cBitTimer.sv
hw/i2cBurstReader.sv
hw/sampleSequencer.sv
hw/axisAssembler.sv
hw/imuSampler.sv
tb/mpuSlaveModel.sv
tb/imuSampler_properties.sv
tb/imuSampler_tb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the imuSampler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module imuSampler_tb \
    -f imuSampler.f \
    -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "Simulation log has no final result"
    exit 1
fi
exit 0

// ==== tb/imuSampler_stimulus.txt ====
// nak hold rnd | gyro regs 43..48 | accel regs 3B..40 | expected gX gY gZ aX aY aZ | err
// rnd 1 replaces the register bytes with random ones, expected columns then unused
0 0 0 01 02 03 04 05 06 11 12 13 14 15 16 0102 0304 0506 1112 1314 1516 0
0 0 0 FF FE 80 00 7F FF C0 00 FF FF 80 01 FFFE 8000 7FFF C000 FFFF 8001 0
1 0 0 AA AA AA AA AA AA AA AA AA AA AA AA FFFE 8000 7FFF C000 FFFF 8001 1
0 0 1 00 00 00 00 00 00 00 00 00 00 00 00 0000 0000 0000 0000 0000 0000 0
0 1 0 10 20 30 40 50 60 70 80 90 A0 B0 C0 1020 3040 5060 7080 90A0 B0C0 0
0 1 0 21 43 65 87 A9 CB ED 0F 12 34 56 78 2143 6587 A9CB ED0F 1234 5678 0
0 0 0 0A 0B 0C 0D 0E 0F F0 E0 D0 C0 B0 A0 0A0B 0C0D 0E0F F0E0 D0C0 B0A0 0
1 0 0 55 55 55 55 55 55 55 55 55 55 55 55 0A0B 0C0D 0E0F F0E0 D0C0 B0A0 1

// ==== tb/imuSampler_tb.sv ====
module imuSampler_tb import imuPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ackTimeout = 5000;

    logic clk;
    logic rst_n;
    logic sampleReq;
    logic sampleAck;
    logic sampleError;
    axisWord gyroX;
    axisWord gyroY;
    axisWord gyroZ;
    axisWord accelX;
    axisWord accelY;
    axisWord accelZ;
    logic scl;
    wire sda;

    axisWord axisOut [6];
    string names [6] = '{"gyroX", "gyroY", "gyroZ", "accelX", "accelY", "accelZ"};
    int errorCount;
    int checkCount;
    int seed;

    // Bus pull-up
    pullup (sda);

    imuSampler i_imuSampler (
        .clk(clk),
        .rst_n(rst_n),
        .sampleReq(sampleReq),
        .sampleAck(sampleAck),
        .sampleError(sampleError),
        .gyroX(gyroX),
        .gyroY(gyroY),
        .gyroZ(gyroZ),
        .accelX(accelX),
        .accelY(accelY),
        .accelZ(accelZ),
        .scl(scl),
        .sda(sda)
    );

    mpuSlaveModel slave (.scl(scl), .sda(sda));

    bind imuSampler imuSampler_properties i_properties (
        .clk(clk), .rst_n(rst_n), .sampleAck(sampleAck), .sampleError(sampleError),
        .scl(scl), .gyroX(gyroX), .gyroY(gyroY), .gyroZ(gyroZ),
        .accelX(accelX), .accelY(accelY), .accelZ(accelZ)
    );

    always #5 clk = ~clk;

    always_comb begin
        axisOut[0] = gyroX;
        axisOut[1] = gyroY;
        axisOut[2] = gyroZ;
        axisOut[3] = accelX;
        axisOut[4] = accelY;
        axisOut[5] = accelZ;
    end

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // Polls on falling edges, seen stays low on timeout
    task automatic waitForAck(output bit seen);
        seen = 1'b0;
        for (int n = 0; n < ackTimeout && !seen; n++) begin
            @(negedge clk);
            seen = sampleAck;
        end
    endtask

    initial begin
        int fd;
        string line;
        int fields;
        int b [12];
        int expAxis [6];
        int nak;
        int hold;
        int rnd;
        int expErr;
        int testNum;
        int errorsBefore;
        bit seen;
        clk = 1'b0;
        rst_n = 1'b1;
        sampleReq = 1'b0;
        errorCount = 0;
        checkCount = 0;
        seed = 32'h8a82;
        testNum = 0;
        // Falling edge so the asynchronous reset always fires
        #1 rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;

        ////////////////////////////////////////////////////////////
        // Idle after reset
        ////////////////////////////////////////////////////////////
        for (int n = 0; n < 20; n++) begin
            @(negedge clk);
            compareValue("sampleAck", sampleAck, 0);
        end
        for (int i = 0; i < 6; i++) begin
            compareValue(names[i], 32'(unsigned'(axisOut[i])), 0);
        end
        $display("Test 0 finished, %0d mismatches", errorCount);

        fd = $fopen("tb/imuSampler_stimulus.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open the stimulus file");
        end else begin

            ////////////////////////////////////////////////////////////
            // One sample per stimulus line
            ////////////////////////////////////////////////////////////
            while ($fgets(line, fd) > 0) begin
                if (line.len() < 2 || line.substr(0, 1) == "//") begin
                    continue;
                end
                fields = $sscanf(line,
                    "%d %d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d",
                    nak, hold, rnd, b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7],
                    b[8], b[9], b[10], b[11], expAxis[0], expAxis[1], expAxis[2],
                    expAxis[3], expAxis[4], expAxis[5], expErr);
                if (fields != 22) begin
                    errorCount++;
                    $display("Stimulus line could not be parsed: %s", line);
                    continue;
                end
                testNum++;
                errorsBefore = errorCount;
                if (rnd != 0) begin
                    for (int k = 0; k < 12; k++) begin
                        b[k] = $random(seed) & 8'hff;
                    end
                    // Big endian, high byte at the even register
                    for (int i = 0; i < 6; i++) begin
                        expAxis[i] = (b[2 * i] << 8) | b[2 * i + 1];
                    end
                end
                for (int k = 0; k < 6; k++) begin
                    slave.regs[8'h43 + k] = 8'(b[k]);
                    slave.regs[8'h3B + k] = 8'(b[6 + k]);
                end
                slave.withholdAck = (nak != 0);
                slave.pointerLog.delete();

                @(posedge clk);
                #1 sampleReq = 1'b1;
                waitForAck(seen);
                if (!seen) begin
                    errorCount++;
                    $display("No sampleAck within %0d cycles in test %0d",
                             ackTimeout, testNum);
                    break;
                end
                compareValue("sampleError", sampleError, expErr);

                // Held request starts the next sample right away
                @(posedge clk);
                #1 sampleReq = (hold != 0);
                @(negedge clk);
                for (int i = 0; i < 6; i++) begin
                    compareValue(names[i], 32'(unsigned'(axisOut[i])), expAxis[i]);
                    compareValue({names[i], " negative"}, axisOut[i] < 0, expAxis[i][15]);
                end

                if (nak != 0) begin
                    compareValue("pointer count", slave.pointerLog.size(), 0);
                end else begin
                    compareValue("pointer count", slave.pointerLog.size(), 2);
                    if (slave.pointerLog.size() == 2) begin
                        compareValue("gyro pointer", slave.pointerLog[0], 8'h43);
                        compareValue("accel pointer", slave.pointerLog[1], 8'h3B);
                    end
                end
                $display("Test %0d finished, %0d mismatches", testNum,
                         errorCount - errorsBefore);
            end
            $fclose(fd);
        end

        $display("Checks: %0d, mismatches: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== tb/imuSampler_properties.sv ====
module imuSampler_properties import imuPkg::*; (
    input logic clk,
    input logic rst_n,
    input logic sampleAck,
    input logic sampleError,
    input logic scl,
    input axisWord gyroX,
    input axisWord gyroY,
    input axisWord gyroZ,
    input axisWord accelX,
    input axisWord accelY,
    input axisWord accelZ
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [95:0] axes;

    assign axes = {gyroX, gyroY, gyroZ, accelX, accelY, accelZ};

    ackOnePulse: assert property (@(posedge clk) disable iff (!rst_n)
        sampleAck |=> !sampleAck)
        else $error("sampleAck high for more than one cycle");

    errorWithAck: assert property (@(posedge clk) disable iff (!rst_n)
        sampleError |-> sampleAck)
        else $error("sampleError without sampleAck");

    // Bus idle and no ack while reset is held
    resetQuiet: assert property (@(posedge clk)
        !rst_n |-> (scl && !sampleAck))
        else $error("scl low or sampleAck high during reset");

    axesAfterAck: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(axes) |-> $past(sampleAck))
        else $error("axis outputs changed outside the cycle after sampleAck");

endmodule

// ==== tb/mpuSlaveModel.sv ====
module mpuSlaveModel (
    input logic scl,
    inout wire sda
);
    timeunit 1ns;
    timeprecision 100ps;

    // Sensor address with AD0 low
    localparam logic [6:0] ownAddr = 7'h68;

    // Register file, filled by the testbench
    logic [7:0] regs [256];
    logic withholdAck;

    // Register pointers in the order they were written
    logic [7:0] pointerLog [$];

    logic sdaDrive;
    logic [7:0] pointer;

    // Open drain, only ever pulls low
    assign sda = sdaDrive ? 1'b0 : 1'bz;

    task automatic receiveByte(output logic [7:0] value);
        for (int i = 7; i >= 0; i--) begin
            @(posedge scl);
            value[i] = sda;
        end
    endtask

    // Ack held low for one clock, released on its falling edge
    task automatic giveAck();
        @(negedge scl);
        sdaDrive = 1'b1;
        @(negedge scl);
        sdaDrive = 1'b0;
    endtask

    // Start or repeated start, SDA falling while SCL high
    task automatic waitStart();
        do begin
            @(negedge sda);
        end while (scl !== 1'b1);
    endtask

    task automatic sendData(input logic [7:0] value, output logic masterAck);
        for (int i = 7; i >= 0; i--) begin
            sdaDrive = !value[i];
            @(negedge scl);
        end
        sdaDrive = 1'b0;
        @(posedge scl);
        masterAck = (sda === 1'b0);
        @(negedge scl);
    endtask

    task automatic serveTransfer();
        logic [7:0] addrByte;
        logic more;
        receiveByte(addrByte);
        // No ack at all when withheld, master goes to stop
        if (addrByte == {ownAddr, 1'b0} && !withholdAck) begin
            giveAck();
            receiveByte(pointer);
            pointerLog.push_back(pointer);
            giveAck();
            waitStart();
            receiveByte(addrByte);
            if (addrByte == {ownAddr, 1'b1}) begin
                giveAck();
                more = 1'b1;
                // Auto increment until the master nacks
                while (more) begin
                    sendData(regs[pointer], more);
                    pointer = pointer + 8'd1;
                end
            end
        end
    endtask

    initial begin
        sdaDrive = 1'b0;
        withholdAck = 1'b0;
        pointer = '0;
        forever begin
            waitStart();
            serveTransfer();
        end
    end

endmodule

// ==== hw/imuSampler.sv ====
module imuSampler import imuPkg::*; (
    input logic clk,
    input logic rst_n,
    input logic sampleReq,
    output logic sampleAck,
    output logic sampleError,
    output axisWord gyroX,
    output axisWord gyroY,
    output axisWord gyroZ,
    output axisWord accelX,
    output axisWord accelY,
    output axisWord accelZ,
    output logic scl,
    inout wire sda
);

    burstIf burst ();

    logic accelPhase;
    logic commit;
    logic tick;
    logic timerEnable;
    logic sdaLow;
    logic sdaIn;

    ////////////////////////////////////////////////////////////
    // Open-drain SDA, pull-up is off chip
    ////////////////////////////////////////////////////////////

    assign sda = sdaLow ? 1'b0 : 1'bz;
    assign sdaIn = sda;

    sampleSequencer i_sampleSequencer (
        .clk(clk),
        .rst_n(rst_n),
        .sampleReq(sampleReq),
        .sampleAck(sampleAck),
        .sampleError(sampleError),
        .accelPhase(accelPhase),
        .commit(commit),
        .burst(burst.control)
    );

    // Quarter-bit rate for the bus engine
    i2cBitTimer i_i2cBitTimer (
        .clk(clk),
        .rst_n(rst_n),
        .enable(timerEnable),
        .tick(tick)
    );

    i2cBurstReader i_i2cBurstReader (
        .clk(clk),
        .rst_n(rst_n),
        .tick(tick),
        .timerEnable(timerEnable),
        .sclOut(scl),
        .sdaLow(sdaLow),
        .sdaIn(sdaIn),
        .burst(burst.engine)
    );

    axisAssembler i_axisAssembler (
        .clk(clk),
        .rst_n(rst_n),
        .accelPhase(accelPhase),
        .commit(commit),
        .burst(burst.monitor),
        .gyroX(gyroX),
        .gyroY(gyroY),
        .gyroZ(gyroZ),
        .accelX(accelX),
        .accelY(accelY),
        .accelZ(accelZ)
    );

endmodule

// ==== hw/axisAssembler.sv ====
module axisAssembler import imuPkg::*, i2cPkg::*; (
    input logic clk,
    input logic rst_n,
    input logic accelPhase,
    input logic commit,
    burstIf.monitor burst,
    output axisWord gyroX,
    output axisWord gyroY,
    output axisWord gyroZ,
    output axisWord accelX,
    output axisWord accelY,
    output axisWord accelZ
);

    // Bytes seen since the last start
    byteCount count;

    // Gyro in slots 0..2, accel in 3..5
    axisWord staging [axisBytes];
    axisWord shown [axisBytes];
    logic [2:0] slot;

    // Two bytes per axis, high byte first
    assign slot = (accelPhase ? 3'd3 : 3'd0) + 3'(count >> 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (burst.start) begin
            count <= '0;
        end else if (burst.byteValid) begin
            count <= count + 1'b1;
        end
    end

    // Staging set, holds partial data of a running sample
    always_ff @(posedge clk) begin
        if (burst.byteValid) begin
            if (!count[0]) begin
                staging[slot][15:8] <= burst.byteData;
            end else begin
                staging[slot][7:0] <= burst.byteData;
            end
        end
    end

    // Visible set, only updated by a clean sample
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < axisBytes; i++) begin
                shown[i] <= '0;
            end
        end else if (commit) begin
            shown <= staging;
        end
    end

    assign gyroX = shown[0];
    assign gyroY = shown[1];
    assign gyroZ = shown[2];
    assign accelX = shown[3];
    assign accelY = shown[4];
    assign accelZ = shown[5];

endmodule

// ==== hw/sampleSequencer.sv ====
module sampleSequencer import imuPkg::*; (
    input logic clk,
    input logic rst_n,
    input logic sampleReq,
    output logic sampleAck,
    output logic sampleError,
    output logic accelPhase,
    output logic commit,
    burstIf.control burst
);

    typedef enum logic [1:0] {
        idle,
        readGyro,
        readAccel,
        finish
    } seqState;

    seqState state;

    // Any nack during the current sample
    logic errorSeen;

    ////////////////////////////////////////////////////////////
    // Sample ordering, gyro first then accel
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            errorSeen <= 1'b0;
            burst.start <= 1'b0;
        end else begin
            burst.start <= 1'b0;
            case (state)
                idle: begin
                    errorSeen <= 1'b0;
                    if (sampleReq) begin
                        state <= readGyro;
                        burst.start <= 1'b1;
                    end
                end
                readGyro: begin
                    if (burst.done) begin
                        if (burst.nack) begin
                            // Accel burst skipped on a failed gyro read
                            state <= finish;
                            errorSeen <= 1'b1;
                        end else begin
                            state <= readAccel;
                            burst.start <= 1'b1;
                        end
                    end
                end
                readAccel: begin
                    if (burst.done) begin
                        state <= finish;
                        errorSeen <= burst.nack;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Pointer follows the active burst
    assign accelPhase = (state == readAccel);
    assign burst.baseAddr = accelPhase ? accelBase : gyroBase;

    // Ack for one cycle, data committed only on a clean sample
    assign sampleAck = (state == finish);
    assign sampleError = sampleAck && errorSeen;
    assign commit = sampleAck && !errorSeen;

endmodule

// ==== hw/i2cBurstReader.sv ====
module i2cBurstReader import imuPkg::*, i2cPkg::*; (
    input logic clk,
    input logic rst_n,
    input logic tick,
    output logic timerEnable,
    output logic sclOut,
    output logic sdaLow,
    input logic sdaIn,
    burstIf.engine burst
);

    busPhase phase;

    // Quarter within the current bit, and bit within the byte
    logic [1:0] quarter;
    logic [2:0] bitCnt;
    logic [7:0] shiftReg;
    byteCount bytes;

    // 0 device write, 1 register pointer, 2 device read
    logic [1:0] addrStage;
    logic nackSeen;

    logic lastByte;
    logic bitHigh;
    logic sclNext;
    logic sdaNext;

    // Final byte of the burst gets no ack from the master
    assign lastByte = (bytes == byteCount'(axisBytes));

    // SCL high in the two middle quarters of a data bit
    assign bitHigh = (quarter == 2'd1) || (quarter == 2'd2);

    assign timerEnable = (phase != idle);

    ////////////////////////////////////////////////////////////
    // Line levels per phase and quarter
    ////////////////////////////////////////////////////////////

    always_comb begin
        sclNext = 1'b1;
        sdaNext = 1'b0;
        case (phase)
            start: begin
                // SDA falls while SCL high, then SCL drops
                sclNext = (quarter != 2'd3);
                sdaNext = (quarter >= 2'd2);
            end
            restart: begin
                sclNext = bitHigh;
                sdaNext = (quarter >= 2'd2);
            end
            sendByte: begin
                sclNext = bitHigh;
                sdaNext = ~shiftReg[7];
            end
            getAck, readByte: begin
                sclNext = bitHigh;
            end
            sendAck: begin
                sclNext = bitHigh;
                sdaNext = !lastByte;
            end
            stop: begin
                // SDA rises while SCL high
                sclNext = (quarter != 2'd0);
                sdaNext = (quarter <= 2'd1);
            end
            default: begin
                sclNext = 1'b1;
            end
        endcase
    end

    // Registered so the pins never glitch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclOut <= 1'b1;
            sdaLow <= 1'b0;
        end else begin
            sclOut <= sclNext;
            sdaLow <= sdaNext;
        end
    end

    ////////////////////////////////////////////////////////////
    // Phase sequencing, one step per quarter tick
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= idle;
            quarter <= '0;
            bitCnt <= '0;
            shiftReg <= '0;
            bytes <= '0;
            addrStage <= '0;
            nackSeen <= 1'b0;
            burst.byteValid <= 1'b0;
            burst.byteData <= '0;
            burst.done <= 1'b0;
            burst.nack <= 1'b0;
        end else begin
            burst.byteValid <= 1'b0;
            burst.done <= 1'b0;
            if (burst.start && phase == idle) begin
                phase <= start;
                quarter <= '0;
                bitCnt <= '0;
                bytes <= '0;
                addrStage <= '0;
                nackSeen <= 1'b0;
            end else if (tick) begin
                quarter <= quarter + 1'b1;
                case (phase)
                    start, restart: begin
                        if (quarter == 2'd3) begin
                            // R/W bit set only after the repeated start
                            phase <= sendByte;
                            shiftReg <= {devAddr, addrStage[1]};
                            bitCnt <= '0;
                        end
                    end
                    sendByte: begin
                        if (quarter == 2'd3) begin
                            shiftReg <= {shiftReg[6:0], 1'b0};
                            bitCnt <= bitCnt + 1'b1;
                            if (bitCnt == 3'd7) begin
                                phase <= getAck;
                            end
                        end
                    end
                    getAck: begin
                        // High SDA here means no slave answered
                        if (quarter == 2'd1) begin
                            nackSeen <= sdaIn;
                        end
                        if (quarter == 2'd3) begin
                            if (nackSeen) begin
                                phase <= stop;
                            end else if (addrStage == 2'd0) begin
                                phase <= sendByte;
                                shiftReg <= burst.baseAddr;
                                addrStage <= 2'd1;
                            end else if (addrStage == 2'd1) begin
                                phase <= restart;
                                addrStage <= 2'd2;
                            end else begin
                                phase <= readByte;
                                bitCnt <= '0;
                            end
                        end
                    end
                    readByte: begin
                        if (quarter == 2'd1) begin
                            shiftReg <= {shiftReg[6:0], sdaIn};
                            if (bitCnt == 3'd7) begin
                                // Full byte, hand it over next cycle
                                burst.byteValid <= 1'b1;
                                burst.byteData <= {shiftReg[6:0], sdaIn};
                                bytes <= bytes + 1'b1;
                            end
                        end
                        if (quarter == 2'd3) begin
                            bitCnt <= bitCnt + 1'b1;
                            if (bitCnt == 3'd7) begin
                                phase <= sendAck;
                            end
                        end
                    end
                    sendAck: begin
                        if (quarter == 2'd3) begin
                            phase <= lastByte ? stop : readByte;
                        end
                    end
                    stop: begin
                        if (quarter == 2'd3) begin
                            phase <= idle;
                            burst.done <= 1'b1;
                            burst.nack <= nackSeen;
                        end
                    end
                    default: begin
                        phase <= idle;
                    end
                endcase
            end
        end
    end

endmodule

// ==== hw/i2cBitTimer.sv ====
module i2cBitTimer import i2cPkg::*; (
    input logic clk,
    input logic rst_n,
    input logic enable,
    output logic tick
);

    // Wide enough for quarterTicks - 1
    logic [$clog2(quarterTicks)-1:0] count;
    logic wrap;

    // Last cycle of a quarter
    assign wrap = (int'(count) == quarterTicks - 1);

    ////////////////////////////////////////////////////////////
    // Quarter-bit counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!enable) begin
            // Held at zero so a new burst starts a full quarter
            count <= '0;
        end else if (wrap) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // One cycle wide, only while the engine runs
    assign tick = enable && wrap;

endmodule

// ==== hw/burstIf.sv ====
interface burstIf import imuPkg::*; ();

    // Request side
    logic start;
    regAddr baseAddr;

    // Return side, one pulse per received byte
    logic byteValid;
    logic [7:0] byteData;

    // End of burst, nack valid with done
    logic done;
    logic nack;

    modport control (output start, output baseAddr, input done, input nack);

    modport engine (
        input start,
        input baseAddr,
        output byteValid,
        output byteData,
        output done,
        output nack
    );

    modport monitor (input start, input byteValid, input byteData);

endinterface

// ==== hw/i2cPkg.sv ====
package i2cPkg;

    // Clk cycles per quarter of an SCL period
    // One SCL bit is four quarters, 20 clk cycles
    localparam int quarterTicks = 5;

    // Phases of the bus engine
    typedef enum logic [2:0] {
        idle,
        start,
        sendByte,
        getAck,
        restart,
        readByte,
        sendAck,
        stop
    } busPhase;

    // Bytes received within one burst
    typedef logic [2:0] byteCount;

endpackage

// ==== hw/imuPkg.sv ====
package imuPkg;

    ////////////////////////////////////////////////////////////
    // Sensor data types
    ////////////////////////////////////////////////////////////

    // One axis reading, two's complement as the sensor sends it
    typedef logic signed [15:0] axisWord;

    // Register address inside the sensor
    typedef logic [7:0] regAddr;

    ////////////////////////////////////////////////////////////
    // Bus address and register map
    ////////////////////////////////////////////////////////////

    // AD0 pin tied low
    localparam logic [6:0] devAddr = 7'h68;

    // First byte of each burst, X axis high byte
    localparam regAddr gyroBase = 8'h43;
    localparam regAddr accelBase = 8'h3B;

    // Three axes, two bytes each
    localparam int axisBytes = 6;

endpackage
